//--- hdl/mem_pkg.sv
// shared widths and memory operation codes for the data-memory subsystem
// import into any module or interface that handles bus words or op codes

package mem_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // byte write lanes, bit k enables byte k
    typedef logic [3:0] byte_en_t;

    // load/store operation code
    typedef logic [3:0] mem_op_t;

    // sub-word slices used by the load extension
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;

    localparam mem_op_t OP_NONE = 4'b0000;
    localparam mem_op_t OP_LB   = 4'b0001;
    localparam mem_op_t OP_LH   = 4'b0010;
    localparam mem_op_t OP_LW   = 4'b0011;
    localparam mem_op_t OP_LBU  = 4'b0100;
    localparam mem_op_t OP_LHU  = 4'b0101;
    localparam mem_op_t OP_SB   = 4'b1110;
    localparam mem_op_t OP_SH   = 4'b1111;
    localparam mem_op_t OP_SW   = 4'b1000;

    // all four lanes, for whole-word writes
    localparam byte_en_t BE_ALL = 4'b1111;

    // default depth in words, top level overrides it
    localparam int unsigned MEM_WORDS_DEF = 256;

endpackage

//--- hdl/mem_port_if.sv
// one data-memory port: access strobes, lane mask, address and both data paths
// requesters drive controls and get read data back, the memory side is the reverse

interface mem_port_if
    import mem_pkg::*;
();

    // write strobe and read strobe, never both high
    logic     gwe;
    logic     rd;
    byte_en_t be;
    word_t    addr;
    word_t    wdata;
    // valid in the same cycle as rd
    word_t    rdata;

    modport requester (
        output gwe,
        output rd,
        output be,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  gwe,
        input  rd,
        input  be,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- hdl/data_mem.sv
// word-organized data RAM with four byte write lanes
// writes happen at the clock edge, reads are combinational while rd is high

module data_mem
    import mem_pkg::*;
#(
    parameter int unsigned MEM_WORDS = MEM_WORDS_DEF
) (
    input logic        clk,
    mem_port_if.memory bus
);

    localparam int unsigned IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // word index, upper address bits ignored
    assign idx = bus.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (bus.gwe) begin
            for (int k = 0; k < 4; k++) begin
                if (bus.be[k]) begin
                    mem[idx][8*k +: 8] <= bus.wdata[8*k +: 8];
                end
            end
        end
    end

    // zero when nobody reads, so the shared return path stays quiet
    assign bus.rdata = bus.rd ? mem[idx] : '0;

endmodule

//--- hdl/lsu_stage.sv
// two-stage load/store datapath of the RV32 pipeline
// stage 5 forms address, lanes and alignment, stage 6 drives the memory and extends loads

module lsu_stage
    import mem_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  mem_op_t       i_mem_op,
    input  word_t         i_op_a,
    input  word_t         i_op_b,
    input  word_t         i_s_imm,
    output word_t         o_load_data,
    output logic          o_misaligned,
    mem_port_if.requester bus
);

    // stage 5 registers
    mem_op_t op5;
    word_t   op_a5;
    word_t   op_b5;
    word_t   s_imm5;

    // stage 5 decode
    word_t    addr5;
    logic     is_load5;
    logic     is_half5;
    logic     is_word5;
    logic     mis5;
    logic     gwe5;
    logic     rd5;
    byte_en_t be5;
    word_t    wdata5;

    // stage 6 registers
    mem_op_t  op6;
    logic     gwe6;
    logic     rd6;
    byte_en_t be6;
    word_t    addr6;
    word_t    wdata6;
    logic     mis6;

    byte_t ld_byte;
    half_t ld_half;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op5    <= OP_NONE;
            op_a5  <= '0;
            op_b5  <= '0;
            s_imm5 <= '0;
        end else begin
            op5    <= i_mem_op;
            op_a5  <= i_op_a;
            op_b5  <= i_op_b;
            s_imm5 <= i_s_imm;
        end
    end

    // stores use the S-immediate, loads the I-immediate in op_b
    assign addr5 = op5[3] ? (op_a5 + s_imm5) : (op_a5 + op_b5);

    assign is_load5 = (op5 == OP_LB) || (op5 == OP_LH) || (op5 == OP_LW) ||
                      (op5 == OP_LBU) || (op5 == OP_LHU);
    assign is_half5 = (op5 == OP_LH) || (op5 == OP_LHU) || (op5 == OP_SH);
    assign is_word5 = (op5 == OP_LW) || (op5 == OP_SW);

    // byte accesses are always aligned
    assign mis5 = (is_half5 && addr5[0]) || (is_word5 && (addr5[1:0] != 2'b00));

    assign rd5  = is_load5 && !mis5;
    assign gwe5 = op5[3] && !mis5;

    always_comb begin
        be5    = '0;
        wdata5 = op_b5;
        case (op5)
            OP_SB: begin
                be5    = byte_en_t'(4'b0001 << addr5[1:0]);
                wdata5 = {4{op_b5[7:0]}};
            end
            OP_SH: begin
                be5    = addr5[1] ? 4'b1100 : 4'b0011;
                wdata5 = {2{op_b5[15:0]}};
            end
            OP_SW: be5 = BE_ALL;
            default: be5 = '0;
        endcase
        if (mis5) begin
            be5 = '0;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op6    <= OP_NONE;
            gwe6   <= 1'b0;
            rd6    <= 1'b0;
            be6    <= '0;
            addr6  <= '0;
            wdata6 <= '0;
            mis6   <= 1'b0;
        end else begin
            op6    <= op5;
            gwe6   <= gwe5;
            rd6    <= rd5;
            be6    <= be5;
            addr6  <= addr5;
            wdata6 <= wdata5;
            mis6   <= mis5;
        end
    end

    assign bus.gwe   = gwe6;
    assign bus.rd    = rd6;
    assign bus.be    = be6;
    assign bus.addr  = addr6;
    assign bus.wdata = wdata6;

    // addressed byte and halfword of the returned word
    assign ld_byte = bus.rdata[8*addr6[1:0] +: 8];
    assign ld_half = addr6[1] ? bus.rdata[31:16] : bus.rdata[15:0];

    always_comb begin
        case (op6)
            OP_LB:   o_load_data = {{24{ld_byte[7]}}, ld_byte};
            OP_LH:   o_load_data = {{16{ld_half[15]}}, ld_half};
            OP_LW:   o_load_data = bus.rdata;
            OP_LBU:  o_load_data = {24'b0, ld_byte};
            OP_LHU:  o_load_data = {16'b0, ld_half};
            default: o_load_data = '0;
        endcase
        // a misaligned op returns nothing
        if (mis6) begin
            o_load_data = '0;
        end
    end

    assign o_misaligned = mis6;

endmodule

//--- hdl/dbg_port.sv
// host debug access to the data memory, one whole word at a time
// holds a single request until granted, done pulses with the read data

module dbg_port
    import mem_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  logic          i_req,
    input  logic          i_we,
    input  word_t         i_addr,
    input  word_t         i_wdata,
    input  logic          i_grant,
    output word_t         o_rdata,
    output logic          o_busy,
    output logic          o_done,
    mem_port_if.requester bus
);

    logic  pend;
    logic  done;
    logic  fire;
    logic  pend_we;
    word_t pend_addr;
    word_t pend_wdata;
    word_t rdata_q;

    // access happens in the first granted cycle
    assign fire = pend && i_grant;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pend <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= fire;
            if (fire) begin
                pend <= 1'b0;
            end else if (i_req) begin
                pend <= 1'b1;
            end
        end
    end

    // new requests only taken when idle
    always_ff @(posedge clk) begin
        if (!pend && i_req) begin
            pend_we    <= i_we;
            pend_addr  <= i_addr;
            pend_wdata <= i_wdata;
        end
        if (fire && !pend_we) begin
            rdata_q <= bus.rdata;
        end
    end

    assign bus.gwe   = pend && pend_we;
    assign bus.rd    = pend && !pend_we;
    assign bus.be    = BE_ALL;
    assign bus.addr  = pend_addr;
    assign bus.wdata = pend_wdata;

    assign o_rdata = rdata_q;
    assign o_busy  = pend;
    assign o_done  = done;

endmodule

//--- hdl/mem_arbiter.sv
// fixed-priority mux of the load/store stage and the debug port onto the RAM
// the load/store side always wins, the debug side waits for an idle cycle

module mem_arbiter (
    mem_port_if.memory    lsu,
    mem_port_if.memory    dbg,
    mem_port_if.requester ram,
    output logic          o_dbg_grant
);

    logic lsu_act;
    logic dbg_gwe;
    logic dbg_rd;

    assign lsu_act     = lsu.gwe || lsu.rd;
    assign o_dbg_grant = !lsu_act;

    // debug strobes only pass when granted
    assign dbg_gwe = dbg.gwe && o_dbg_grant;
    assign dbg_rd  = dbg.rd && o_dbg_grant;

    always_comb begin
        if (lsu_act) begin
            ram.gwe   = lsu.gwe;
            ram.rd    = lsu.rd;
            ram.be    = lsu.be;
            ram.addr  = lsu.addr;
            ram.wdata = lsu.wdata;
        end else begin
            ram.gwe   = dbg_gwe;
            ram.rd    = dbg_rd;
            ram.be    = dbg.be;
            ram.addr  = dbg.addr;
            ram.wdata = dbg.wdata;
        end
    end

    // shared return path, each side reads it only during its own access
    assign lsu.rdata = ram.rdata;
    assign dbg.rdata = ram.rdata;

endmodule

//--- hdl/mem_subsys.sv
// data-memory subsystem top: load/store stage and debug port sharing one RAM
// plain ports outward, memory ports carried as interfaces inside

module mem_subsys
    import mem_pkg::*;
#(
    parameter int unsigned MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic    clk,
    input  logic    nrst,
    input  mem_op_t i_mem_op,
    input  word_t   i_op_a,
    input  word_t   i_op_b,
    input  word_t   i_s_imm,
    output word_t   o_load_data,
    output logic    o_misaligned,
    input  logic    i_dbg_req,
    input  logic    i_dbg_we,
    input  word_t   i_dbg_addr,
    input  word_t   i_dbg_wdata,
    output word_t   o_dbg_rdata,
    output logic    o_dbg_busy,
    output logic    o_dbg_done
);

    logic dbg_grant;

    mem_port_if lsu_bus ();
    mem_port_if dbg_bus ();
    mem_port_if ram_bus ();

    lsu_stage i_lsu_stage (
        .clk          (clk),
        .nrst         (nrst),
        .i_mem_op     (i_mem_op),
        .i_op_a       (i_op_a),
        .i_op_b       (i_op_b),
        .i_s_imm      (i_s_imm),
        .o_load_data  (o_load_data),
        .o_misaligned (o_misaligned),
        .bus          (lsu_bus.requester)
    );

    dbg_port i_dbg_port (
        .clk     (clk),
        .nrst    (nrst),
        .i_req   (i_dbg_req),
        .i_we    (i_dbg_we),
        .i_addr  (i_dbg_addr),
        .i_wdata (i_dbg_wdata),
        .i_grant (dbg_grant),
        .o_rdata (o_dbg_rdata),
        .o_busy  (o_dbg_busy),
        .o_done  (o_dbg_done),
        .bus     (dbg_bus.requester)
    );

    mem_arbiter i_mem_arbiter (
        .lsu         (lsu_bus.memory),
        .dbg         (dbg_bus.memory),
        .ram         (ram_bus.requester),
        .o_dbg_grant (dbg_grant)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) i_data_mem (
        .clk (clk),
        .bus (ram_bus.memory)
    );

endmodule

//--- verification/mem_subsys_sva.sv
// concurrent checks on memory arbitration, bound into the subsystem top
// covers load/store priority, strobe exclusivity and the quiet memory after reset

module mem_subsys_sva
    import mem_pkg::*;
(
    input logic    clk,
    input logic    nrst,
    input mem_op_t i_mem_op,
    input logic    i_dbg_req,
    input logic    i_lsu_gwe,
    input logic    i_lsu_rd,
    input logic    i_ram_gwe,
    input logic    i_ram_rd,
    input logic    i_dbg_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // set by the first request of either peer after reset
    logic req_seen;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_seen <= 1'b0;
        end else if ((i_mem_op != OP_NONE) || i_dbg_req) begin
            req_seen <= 1'b1;
        end
    end

    // the debug port never completes in a cycle the load/store stage owned
    a_lsu_priority: assert property (@(posedge clk) disable iff (!nrst)
        (i_lsu_gwe || i_lsu_rd) |=> !i_dbg_done)
        else $error("debug access completed during a load/store access");

    a_ram_strobes: assert property (@(posedge clk) disable iff (!nrst)
        !(i_ram_gwe && i_ram_rd))
        else $error("ram write and read strobes high together");

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!nrst)
        (i_ram_gwe || i_ram_rd) |-> req_seen)
        else $error("ram access before any request since reset");

endmodule

//--- verification/tb_mem_subsys.sv
// testbench for the data-memory subsystem
// runs the vectors in verification/mem_tests.txt, then a load stream against a debug read

module tb_mem_subsys
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT  = 50;
    localparam int N_STREAM = 12;

    logic    clk;
    logic    nrst;
    mem_op_t mem_op;
    word_t   op_a;
    word_t   op_b;
    word_t   s_imm;
    word_t   load_data;
    logic    misaligned;
    logic    dbg_req;
    logic    dbg_we;
    word_t   dbg_addr;
    word_t   dbg_wdata;
    word_t   dbg_rdata;
    logic    dbg_busy;
    logic    dbg_done;

    int    n_pass;
    int    n_fail;
    word_t lcg_state;
    // memory words known from debug accesses, by byte address
    word_t model [word_t];
    word_t known [$];

    mem_subsys #(
        .MEM_WORDS (256)
    ) i_mem_subsys (
        .clk          (clk),
        .nrst         (nrst),
        .i_mem_op     (mem_op),
        .i_op_a       (op_a),
        .i_op_b       (op_b),
        .i_s_imm      (s_imm),
        .o_load_data  (load_data),
        .o_misaligned (misaligned),
        .i_dbg_req    (dbg_req),
        .i_dbg_we     (dbg_we),
        .i_dbg_addr   (dbg_addr),
        .i_dbg_wdata  (dbg_wdata),
        .o_dbg_rdata  (dbg_rdata),
        .o_dbg_busy   (dbg_busy),
        .o_dbg_done   (dbg_done)
    );

    bind mem_subsys mem_subsys_sva i_mem_subsys_sva (
        .clk        (clk),
        .nrst       (nrst),
        .i_mem_op   (i_mem_op),
        .i_dbg_req  (i_dbg_req),
        .i_lsu_gwe  (lsu_bus.gwe),
        .i_lsu_rd   (lsu_bus.rd),
        .i_ram_gwe  (ram_bus.gwe),
        .i_ram_rd   (ram_bus.rd),
        .i_dbg_done (o_dbg_done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual === expected) begin
            n_pass++;
            $display("ok     %s data %08h", name, actual);
        end else begin
            n_fail++;
            $display("FAILED %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            n_pass++;
            $display("ok     %s flag %b", name, actual);
        end else begin
            n_fail++;
            $display("FAILED %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic wait_dbg_done(input string name, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < TIMEOUT && !seen; i++) begin
            @(posedge clk);
            #1;
            seen = dbg_done;
        end
        if (!seen) begin
            n_fail++;
            $display("%s: debug access did not complete within %0d cycles", name, TIMEOUT);
        end
    endtask

    // one op in flight, result valid two edges after it is sampled
    task automatic lsu_op(input string name, input mem_op_t op, input word_t a,
                          input word_t b, input word_t imm, input word_t exp,
                          input logic mis);
        @(posedge clk);
        #2;
        mem_op = op;
        op_a   = a;
        op_b   = b;
        s_imm  = imm;
        @(posedge clk);
        #2;
        mem_op = OP_NONE;
        @(posedge clk);
        #10;
        check_word(name, exp, load_data);
        check_flag(name, mis, misaligned);
    endtask

    task automatic dbg_access(input string name, input logic we, input word_t addr,
                              input word_t wdata, input word_t exp);
        logic seen;
        @(posedge clk);
        #2;
        dbg_req   = 1'b1;
        dbg_we    = we;
        dbg_addr  = addr;
        dbg_wdata = wdata;
        @(posedge clk);
        #2;
        dbg_req = 1'b0;
        wait_dbg_done(name, seen);
        if (seen && we) begin
            check_flag(name, 1'b0, dbg_busy);
        end else if (seen) begin
            check_word(name, exp, dbg_rdata);
        end
    endtask

    task automatic apply_vectors();
        int    fd;
        int    n;
        string line;
        string name;
        string kind;
        word_t f_op;
        word_t a;
        word_t b;
        word_t imm;
        word_t exp;
        word_t mis;
        fd = $fopen("verification/mem_tests.txt", "r");
        if (fd == 0) begin
            n_fail++;
            $display("could not open the test vector file");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, kind, f_op, a, b, imm, exp, mis);
            if (n == 8 && kind == "D") begin
                if (!model.exists(a)) begin
                    known.push_back(a);
                end
                model[a] = f_op[0] ? b : exp;
                dbg_access(name, f_op[0], a, b, exp);
            end else if (n == 8) begin
                lsu_op(name, f_op[3:0], a, b, imm, exp, mis[0]);
            end
        end
        $fclose(fd);
    endtask

    // back-to-back loads hold the memory, the debug read has to wait them out
    task automatic contention_stream();
        word_t exp_q [$];
        word_t addr;
        word_t w;
        word_t rd_addr;
        int    idx;
        int    off;
        logic  seen;
        rd_addr = known[known.size() - 1];
        for (int c = 0; c < N_STREAM + 2; c++) begin
            @(posedge clk);
            #1;
            if (c >= 2) begin
                check_word($sformatf("stream%0d", c - 2), exp_q.pop_front(), load_data);
            end
            if (dbg_done) begin
                n_fail++;
                $display("debug access finished while the load stream held the memory");
            end
            // request latched long ago and still waiting on the last load
            if (c == N_STREAM + 1) begin
                check_flag("contention_busy", 1'b1, dbg_busy);
            end
            #1;
            dbg_req  = (c == 3);
            dbg_we   = 1'b0;
            dbg_addr = rd_addr;
            mem_op   = OP_NONE;
            if (c < N_STREAM) begin
                lcg_state = lcg_next(lcg_state);
                idx  = int'(lcg_state[15:8]) % known.size();
                off  = int'(lcg_state[5:4]);
                addr = known[idx];
                w    = model[addr];
                op_a  = addr;
                s_imm = lcg_state;
                if (lcg_state[0]) begin
                    mem_op = OP_LW;
                    op_b   = '0;
                    exp_q.push_back(w);
                end else begin
                    mem_op = OP_LBU;
                    op_b   = {30'b0, lcg_state[5:4]};
                    exp_q.push_back({24'b0, w[8*off +: 8]});
                end
            end
        end
        wait_dbg_done("contention", seen);
        if (seen) begin
            check_word("contention_dbg", model[rd_addr], dbg_rdata);
        end
    endtask

    initial begin
        nrst      = 1'b0;
        mem_op    = OP_NONE;
        op_a      = '0;
        op_b      = '0;
        s_imm     = '0;
        dbg_req   = 1'b0;
        dbg_we    = 1'b0;
        dbg_addr  = '0;
        dbg_wdata = '0;
        n_pass    = 0;
        n_fail    = 0;
        lcg_state = 32'hadbf1d99;
        repeat (16) @(posedge clk);
        #2;
        nrst = 1'b1;
        apply_vectors();
        if (known.size() > 0) begin
            contention_stream();
        end else begin
            n_fail++;
            $display("no debug words were read from the vector file");
        end
        repeat (4) @(posedge clk);
        $display("checks passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // run limit
    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Errors found");
        $finish;
    end

endmodule

//--- verification/mem_tests.txt
# name kind op a b s_imm expected mis, numbers in hex
# D lines: op column is the write flag, a the address, b the write data
dw_a    D 1 00000040 a1b2c3d4 0        0        0
dw_b    D 1 00000048 11223344 0        0        0
dw_c    D 1 0000004c deadbeef 0        0        0
dr_a    D 0 00000040 00000000 0        a1b2c3d4 0
lw_a    L 3 00000030 00000010 0        a1b2c3d4 0
sb_0    L e 00000048 000000aa 0        0        0
sb_1    L e 00000040 0000005b 9        0        0
sb_2    L e 00000048 ffffffc6 2        0        0
sb_3    L e 00000050 0000007d fffffffb 0        0
dr_b    D 0 00000048 00000000 0        7dc65baa 0
sh_0    L f 0000004c 12348001 0        0        0
sh_2    L f 0000004c 0000f00d 2        0        0
dr_c    D 0 0000004c 00000000 0        f00d8001 0
lb_0    L 1 00000048 00000000 0        ffffffaa 0
lb_3    L 1 00000040 0000000b 0        0000007d 0
lbu_2   L 4 00000048 00000002 0        000000c6 0
lbu_1   L 4 00000048 00000001 0        0000005b 0
lh_0    L 2 0000004c 00000000 0        ffff8001 0
lh_2    L 2 00000048 00000002 0        00007dc6 0
lhu_2   L 5 0000004c 00000002 0        0000f00d 0
mis_lh  L 2 00000048 00000001 0        0        1
mis_lhu L 5 0000004c 00000003 0        0        1
mis_lw  L 3 00000040 00000002 0        0        1
mis_sh  L f 00000048 0000ffff 3        0        1
mis_sw  L 8 0000004c 00000000 1        0        1
dm_b    D 0 00000048 00000000 0        7dc65baa 0
dm_c    D 0 0000004c 00000000 0        f00d8001 0
sw_0    L 8 00000040 cafe1234 10       0        0
dr_d    D 0 00000050 00000000 0        cafe1234 0
lw_d    L 3 00000050 00000000 0        cafe1234 0

//--- project.f
hdl/mem_pkg.sv
hdl/mem_port_if.sv
hdl/data_mem.sv
hdl/lsu_stage.sv
hdl/dbg_port.sv
hdl/mem_arbiter.sv
hdl/mem_subsys.sv
verification/mem_subsys_sva.sv
verification/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem_subsys -f project.f &&
    ./obj_dir/Vtb_mem_subsys | tee /dev/stderr | grep -qx "No errors" &&
    { echo "simulation passed"; exit 0; } ||
    { echo "simulation failed"; exit 1; }
